//--- divider_proj.f
+incdir+hw
hw/div_data_pkg.sv
hw/div_ctrl_pkg.sv
hw/div_leading_one.sv
hw/div_operand_prep.sv
hw/div_fsm.sv
hw/div_datapath.sv
hw/divider.sv
verification/divider_tb.sv

//--- hw/div_consts.svh
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand and result width
`define DIV_WIDTH 32

// digit count width, holds 0 to DIV_WIDTH
`define DIV_DIGIT_W 6

// longest run of shift-subtract steps
`define DIV_MAX_ITER (`DIV_WIDTH + 1)

`endif

//--- hw/div_ctrl_pkg.sv
package div_ctrl_pkg;

    // divider controller states
    typedef enum logic [2:0] {
        DIV_IDLE  = 3'd0,
        // operands captured, divisor gets aligned
        DIV_LOAD  = 3'd1,
        // early exit decision
        DIV_CHECK = 3'd2,
        // one quotient digit per cycle
        DIV_ITER  = 3'd3,
        // result signs applied
        DIV_FINAL = 3'd4,
        DIV_DONE  = 3'd5
    } div_state_e;

endpackage

//--- hw/div_data_pkg.sv
`include "div_consts.svh"

package div_data_pkg;

    // operands, quotient and remainder
    typedef logic [`DIV_WIDTH-1:0] div_word_t;

    // two's complement view of an operand
    typedef struct packed {
        logic                  msb;
        logic [`DIV_WIDTH-2:0] low;
    } div_signed_view_t;

    // one operand word, read as magnitude or as signed value
    typedef union packed {
        div_word_t        magnitude;
        div_signed_view_t signed_view;
    } div_operand_u;

    // significant digits of a word, zero for a zero word
    typedef logic [`DIV_DIGIT_W-1:0] div_digits_t;

endpackage

//--- hw/div_datapath.sv
`timescale 1ns/100ps
`include "div_consts.svh"

module div_datapath (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      flush_exception,
    input  logic                      start,
    input  logic                      sign,
    input  logic                      dividend_sign,
    input  logic                      divisor_sign,
    input  div_data_pkg::div_word_t   dividend_abs,
    input  div_data_pkg::div_word_t   divisor_abs,
    input  div_data_pkg::div_digits_t dividend_digits,
    input  div_data_pkg::div_digits_t divisor_digits,
    input  div_ctrl_pkg::div_state_e  state,
    output logic                      early_out,
    output logic                      last_iter,
    output div_data_pkg::div_word_t   quotient,
    output div_data_pkg::div_word_t   remainder
);

    // captured operation
    logic                      sign_r;
    logic                      dividend_sign_r;
    logic                      divisor_sign_r;
    div_data_pkg::div_digits_t dividend_digits_r;
    div_data_pkg::div_digits_t divisor_digits_r;
    div_data_pkg::div_digits_t iter_cnt;
    div_data_pkg::div_digits_t iter_total;

    // partial remainder, aligned divisor, quotient bits
    div_data_pkg::div_word_t   rem_acc;
    div_data_pkg::div_word_t   quo_acc;
    logic [2*`DIV_WIDTH-1:0]   divisor_sh;
    logic [2*`DIV_WIDTH-1:0]   divisor_nxt;
    logic [2*`DIV_WIDTH-1:0]   trial;
    logic                      trial_ok;

    // signed result, held until DIV_DONE
    div_data_pkg::div_word_t   quo_signed;
    div_data_pkg::div_word_t   rem_signed;
    div_data_pkg::div_word_t   res_quo;
    div_data_pkg::div_word_t   res_rem;

    assign iter_total = dividend_digits_r - divisor_digits_r + 1'b1;

    // zero divisor or divisor wider than dividend
    assign early_out = (state == div_ctrl_pkg::DIV_CHECK) &&
                       ((divisor_digits_r == '0) || (divisor_digits_r > dividend_digits_r));
    assign last_iter = (state == div_ctrl_pkg::DIV_ITER) && (iter_cnt == iter_total);

    // restoring step
    assign divisor_nxt = divisor_sh >> 1;
    assign trial       = {{`DIV_WIDTH{1'b0}}, rem_acc} - divisor_nxt;
    assign trial_ok    = !trial[2*`DIV_WIDTH-1];

    // quotient follows the sign xor, remainder the dividend sign
    assign quo_signed = (sign_r && (dividend_sign_r ^ divisor_sign_r)) ? ~quo_acc + 1'b1 : quo_acc;
    assign rem_signed = (sign_r && dividend_sign_r) ? ~rem_acc + 1'b1 : rem_acc;

    always_ff @(posedge clk) begin
        if (!rstn || flush_exception) begin
            sign_r            <= 1'b0;
            dividend_sign_r   <= 1'b0;
            divisor_sign_r    <= 1'b0;
            dividend_digits_r <= '0;
            divisor_digits_r  <= '0;
            iter_cnt          <= '0;
        end else if (start) begin
            sign_r            <= sign;
            dividend_sign_r   <= dividend_sign;
            divisor_sign_r    <= divisor_sign;
            dividend_digits_r <= dividend_digits;
            divisor_digits_r  <= divisor_digits;
            iter_cnt          <= '0;
        end else begin
            case (state)
                div_ctrl_pkg::DIV_LOAD: begin
                    iter_cnt <= div_data_pkg::div_digits_t'(1);
                end
                div_ctrl_pkg::DIV_ITER: begin
                    // stop counting on the last step
                    if (!last_iter) begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_acc    <= dividend_abs;
            quo_acc    <= '0;
            divisor_sh <= {{`DIV_WIDTH{1'b0}}, divisor_abs};
        end else begin
            case (state)
                div_ctrl_pkg::DIV_LOAD: begin
                    // one position above the top quotient digit
                    divisor_sh <= divisor_sh << iter_total;
                end
                div_ctrl_pkg::DIV_ITER: begin
                    divisor_sh <= divisor_nxt;
                    quo_acc    <= {quo_acc[`DIV_WIDTH-2:0], trial_ok};
                    if (trial_ok) begin
                        rem_acc <= trial[`DIV_WIDTH-1:0];
                    end
                end
                default: begin
                end
            endcase
        end
        // early exit leaves quo_acc zero and rem_acc the dividend
        if (early_out || (state == div_ctrl_pkg::DIV_FINAL)) begin
            res_quo <= quo_signed;
            res_rem <= rem_signed;
        end
    end

    // result visible in the done cycle only
    assign quotient  = (state == div_ctrl_pkg::DIV_DONE) ? res_quo : '0;
    assign remainder = (state == div_ctrl_pkg::DIV_DONE) ? res_rem : '0;

    // loop length bounded by the digit counts from prep
    a_iter_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        (state == div_ctrl_pkg::DIV_ITER) |-> (iter_cnt <= `DIV_MAX_ITER)
    );

endmodule

//--- hw/div_fsm.sv
`timescale 1ns/100ps

module div_fsm (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     en,
    input  logic                     flush_exception,
    input  logic                     early_out,
    input  logic                     last_iter,
    output div_ctrl_pkg::div_state_e state,
    output logic                     ready,
    output logic                     stall_divider
);

    div_ctrl_pkg::div_state_e state_nxt;

    // flush wins over everything but reset
    always_ff @(posedge clk) begin
        if (!rstn || flush_exception) begin
            state <= div_ctrl_pkg::DIV_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            div_ctrl_pkg::DIV_IDLE: begin
                // en only counts while idle
                if (en) begin
                    state_nxt = div_ctrl_pkg::DIV_LOAD;
                end
            end
            div_ctrl_pkg::DIV_LOAD: begin
                state_nxt = div_ctrl_pkg::DIV_CHECK;
            end
            div_ctrl_pkg::DIV_CHECK: begin
                if (early_out) begin
                    state_nxt = div_ctrl_pkg::DIV_DONE;
                end else begin
                    state_nxt = div_ctrl_pkg::DIV_ITER;
                end
            end
            div_ctrl_pkg::DIV_ITER: begin
                if (last_iter) begin
                    state_nxt = div_ctrl_pkg::DIV_FINAL;
                end
            end
            div_ctrl_pkg::DIV_FINAL: begin
                state_nxt = div_ctrl_pkg::DIV_DONE;
            end
            div_ctrl_pkg::DIV_DONE: begin
                state_nxt = div_ctrl_pkg::DIV_IDLE;
            end
            default: begin
                state_nxt = div_ctrl_pkg::DIV_IDLE;
            end
        endcase
    end

    // done pulse and busy level
    assign ready         = (state == div_ctrl_pkg::DIV_DONE);
    assign stall_divider = (state != div_ctrl_pkg::DIV_IDLE);

    // single-cycle done pulse
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        ready |=> !ready
    );

    // the pipeline must still be held when the result shows up
    a_ready_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        ready |-> stall_divider
    );

endmodule

//--- hw/div_leading_one.sv
`timescale 1ns/100ps
`include "div_consts.svh"

module div_leading_one (
    input  div_data_pkg::div_word_t   value,
    output div_data_pkg::div_digits_t digits
);

    // priority search, highest set bit wins
    always_comb begin
        digits = '0;
        for (int i = 0; i < `DIV_WIDTH; i++) begin
            if (value[i]) begin
                digits = div_data_pkg::div_digits_t'(i + 1);
            end
        end
    end

endmodule

//--- hw/div_operand_prep.sv
`timescale 1ns/100ps

module div_operand_prep (
    input  logic                       sign,
    input  div_data_pkg::div_operand_u dividend,
    input  div_data_pkg::div_operand_u divisor,
    output div_data_pkg::div_word_t    dividend_abs,
    output div_data_pkg::div_word_t    divisor_abs,
    output div_data_pkg::div_digits_t  dividend_digits,
    output div_data_pkg::div_digits_t  divisor_digits
);

    // negate only for a signed op with the top bit set
    function automatic div_data_pkg::div_word_t magnitude(
        input logic                       signed_op,
        input div_data_pkg::div_operand_u op
    );
        if (signed_op && op.signed_view.msb) begin
            return ~op.magnitude + 1'b1;
        end
        return op.magnitude;
    endfunction

    assign dividend_abs = magnitude(sign, dividend);
    assign divisor_abs  = magnitude(sign, divisor);

    // digit counts drive early exit and loop length
    div_leading_one u_dividend_digits (
        .value  (dividend_abs),
        .digits (dividend_digits)
    );

    div_leading_one u_divisor_digits (
        .value  (divisor_abs),
        .digits (divisor_digits)
    );

endmodule

//--- hw/divider.sv
`timescale 1ns/100ps
`include "div_consts.svh"

module divider (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    en,
    input  logic                    sign,
    input  div_data_pkg::div_word_t dividend,
    input  div_data_pkg::div_word_t divisor,
    input  logic                    flush_exception,
    output div_data_pkg::div_word_t quotient,
    output div_data_pkg::div_word_t remainder,
    output logic                    ready,
    output logic                    stall_divider
);

    div_data_pkg::div_word_t   dividend_abs;
    div_data_pkg::div_word_t   divisor_abs;
    div_data_pkg::div_digits_t dividend_digits;
    div_data_pkg::div_digits_t divisor_digits;
    div_ctrl_pkg::div_state_e  state;
    logic                      early_out;
    logic                      last_iter;
    logic                      start;

    // capture only when the controller accepts en
    assign start = en && (state == div_ctrl_pkg::DIV_IDLE);

    div_operand_prep u_prep (
        .sign            (sign),
        .dividend        (dividend),
        .divisor         (divisor),
        .dividend_abs    (dividend_abs),
        .divisor_abs     (divisor_abs),
        .dividend_digits (dividend_digits),
        .divisor_digits  (divisor_digits)
    );

    div_fsm u_fsm (
        .clk             (clk),
        .rstn            (rstn),
        .en              (en),
        .flush_exception (flush_exception),
        .early_out       (early_out),
        .last_iter       (last_iter),
        .state           (state),
        .ready           (ready),
        .stall_divider   (stall_divider)
    );

    div_datapath u_datapath (
        .clk             (clk),
        .rstn            (rstn),
        .flush_exception (flush_exception),
        .start           (start),
        .sign            (sign),
        .dividend_sign   (dividend[`DIV_WIDTH-1]),
        .divisor_sign    (divisor[`DIV_WIDTH-1]),
        .dividend_abs    (dividend_abs),
        .divisor_abs     (divisor_abs),
        .dividend_digits (dividend_digits),
        .divisor_digits  (divisor_digits),
        .state           (state),
        .early_out       (early_out),
        .last_iter       (last_iter),
        .quotient        (quotient),
        .remainder       (remainder)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# builds and runs the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f divider_proj.f \
        --top-module divider_tb -o divider_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/divider_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

grep -q "ERRORS FOUND" "$LOG"
status=$?
if [ "$status" -eq 0 ]; then
    echo "result: fail"
    exit 1
elif [ "$status" -ne 1 ]; then
    echo "could not search $LOG"
    exit 1
fi

echo "result: pass"
exit 0

//--- verification/divider_tb.sv
`timescale 1ns/100ps

module divider_tb;

    typedef div_data_pkg::div_word_t word_t;

    // watchdog budget: operations times worst case per operation, plus slack
    localparam int NUM_OPS        = 250;
    localparam int OP_CYCLES      = 40;
    localparam int TIMEOUT_CYCLES = NUM_OPS * OP_CYCLES + 2000;
    localparam int MAX_LATENCY    = 40;

    logic  clk;
    logic  rstn;
    logic  en;
    logic  sign;
    word_t dividend;
    word_t divisor;
    logic  flush_exception;
    word_t quotient;
    word_t remainder;
    logic  ready;
    logic  stall_divider;

    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int cycle_cnt;

    divider u_divider (
        .clk             (clk),
        .rstn            (rstn),
        .en              (en),
        .sign            (sign),
        .dividend        (dividend),
        .divisor         (divisor),
        .flush_exception (flush_exception),
        .quotient        (quotient),
        .remainder       (remainder),
        .ready           (ready),
        .stall_divider   (stall_divider)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, ready never arrived", cycle_cnt);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic int digit_count(input word_t w);
        int    n;
        word_t v;
        n = 0;
        v = w;
        while (v != '0) begin
            v = v >> 1;
            n++;
        end
        return n;
    endfunction

    // result rule and cycle count of one operation
    task automatic expected_result(input logic s, input word_t a, input word_t b,
                                   output word_t q, output word_t r, output int lat);
        word_t a_mag;
        word_t b_mag;
        int    da;
        int    db;
        a_mag = (s && a[31]) ? (32'd0 - a) : a;
        b_mag = (s && b[31]) ? (32'd0 - b) : b;
        if (b_mag == '0) begin
            q = '0;
            r = a_mag;
        end else begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
        end
        if (s && (a[31] != b[31])) begin
            q = 32'd0 - q;
        end
        if (s && a[31]) begin
            r = 32'd0 - r;
        end
        da = digit_count(a_mag);
        db = digit_count(b_mag);
        // load, check, iterations, final, done
        lat = (db == 0 || db > da) ? 3 : (da - db + 5);
    endtask

    task automatic run_division(input logic s, input word_t a, input word_t b,
                                input logic poke_busy);
        word_t exp_q;
        word_t exp_r;
        int    exp_lat;
        int    latency;
        expected_result(s, a, b, exp_q, exp_r, exp_lat);
        @(negedge clk);
        check_flag("stall_divider", 1'b0, stall_divider);
        en       = 1'b1;
        sign     = s;
        dividend = a;
        divisor  = b;
        @(negedge clk);
        en      = 1'b0;
        latency = 1;
        check_flag("stall_divider", 1'b1, stall_divider);
        while (!ready && latency < MAX_LATENCY) begin
            check_word("quotient", '0, quotient);
            check_word("remainder", '0, remainder);
            // start attempts while busy
            if (poke_busy) begin
                en       = 1'b1;
                sign     = ~s;
                dividend = $urandom;
                divisor  = $urandom;
            end
            @(negedge clk);
            en = 1'b0;
            latency++;
        end
        if (!ready) begin
            $display("** Error at %0t: ready never arrived for %h / %h", $time, a, b);
            err_cnt++;
        end else begin
            if (latency != exp_lat) begin
                $display("** Error at %0t: ready came %0d cycles after en, expected %0d",
                         $time, latency, exp_lat);
                err_cnt++;
            end
            check_word("quotient", exp_q, quotient);
            check_word("remainder", exp_r, remainder);
            check_flag("stall_divider", 1'b1, stall_divider);
            @(negedge clk);
            check_flag("ready", 1'b0, ready);
            check_flag("stall_divider", 1'b0, stall_divider);
            check_word("quotient", '0, quotient);
            check_word("remainder", '0, remainder);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int errs_before;
        errs_before = err_cnt;
        @(negedge clk);
        check_flag("ready", 1'b0, ready);
        check_flag("stall_divider", 1'b0, stall_divider);
        check_word("quotient", '0, quotient);
        check_word("remainder", '0, remainder);
        finish_test("reset_state", errs_before);
    endtask

    task automatic test_unsigned();
        int    errs_before;
        word_t a;
        word_t b;
        errs_before = err_cnt;
        run_division(1'b0, 32'd100, 32'd7, 1'b0);
        // divisor larger than dividend
        run_division(1'b0, 32'd7, 32'd100, 1'b0);
        run_division(1'b0, 32'hFFFF_FFFF, 32'd1, 1'b0);
        run_division(1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
        run_division(1'b0, 32'h8000_0000, 32'd3, 1'b0);
        run_division(1'b0, 32'd0, 32'd5, 1'b0);
        run_division(1'b0, 32'd12345678, 32'd1000, 1'b0);
        for (int i = 0; i < 100; i++) begin
            a = $urandom;
            b = $urandom;
            b = b >> ($urandom % 32);
            run_division(1'b0, a, b, 1'b0);
        end
        finish_test("unsigned", errs_before);
    endtask

    task automatic test_signed();
        int    errs_before;
        word_t a;
        word_t b;
        errs_before = err_cnt;
        run_division(1'b1, word_t'(100), word_t'(7), 1'b0);
        run_division(1'b1, word_t'(-100), word_t'(7), 1'b0);
        run_division(1'b1, word_t'(100), word_t'(-7), 1'b0);
        run_division(1'b1, word_t'(-100), word_t'(-7), 1'b0);
        run_division(1'b1, word_t'(-7), word_t'(100), 1'b0);
        // wraps back to the most negative value
        run_division(1'b1, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
        run_division(1'b1, 32'h8000_0000, 32'd1, 1'b0);
        for (int i = 0; i < 100; i++) begin
            a = $urandom;
            b = $urandom;
            b = word_t'($signed(b) >>> ($urandom % 32));
            run_division(1'b1, a, b, 1'b0);
        end
        finish_test("signed", errs_before);
    endtask

    task automatic test_zero_divisor();
        int errs_before;
        errs_before = err_cnt;
        run_division(1'b0, 32'd123456, 32'd0, 1'b0);
        run_division(1'b1, word_t'(-123456), 32'd0, 1'b0);
        run_division(1'b1, 32'h8000_0000, 32'd0, 1'b0);
        finish_test("zero_divisor", errs_before);
    endtask

    task automatic test_busy_en();
        int errs_before;
        errs_before = err_cnt;
        run_division(1'b0, 32'd1000000, 32'd7, 1'b1);
        run_division(1'b1, word_t'(-5000), 32'd3, 1'b1);
        run_division(1'b0, 32'hDEAD_BEEF, 32'd0, 1'b1);
        finish_test("busy_en", errs_before);
    endtask

    task automatic test_flush();
        int   errs_before;
        logic seen_ready;
        errs_before = err_cnt;
        seen_ready  = 1'b0;
        @(negedge clk);
        en       = 1'b1;
        sign     = 1'b0;
        dividend = 32'hFFFF_FFFF;
        divisor  = 32'd1;
        @(negedge clk);
        en = 1'b0;
        // past load and check, a few steps into the loop
        repeat (4) @(negedge clk);
        check_flag("stall_divider", 1'b1, stall_divider);
        flush_exception = 1'b1;
        @(negedge clk);
        flush_exception = 1'b0;
        check_flag("stall_divider", 1'b0, stall_divider);
        check_flag("ready", 1'b0, ready);
        check_word("quotient", '0, quotient);
        check_word("remainder", '0, remainder);
        for (int i = 0; i < MAX_LATENCY; i++) begin
            if (ready) begin
                seen_ready = 1'b1;
            end
            @(negedge clk);
        end
        if (seen_ready) begin
            $display("** Error at %0t: ready pulsed after the operation was flushed", $time);
            err_cnt++;
        end
        run_division(1'b0, 32'd1000, 32'd33, 1'b0);
        finish_test("flush", errs_before);
    endtask

    initial begin
        void'($urandom(71789));
        err_cnt         = 0;
        pass_cnt        = 0;
        fail_cnt        = 0;
        rstn            = 1'b0;
        en              = 1'b0;
        sign            = 1'b0;
        dividend        = '0;
        divisor         = '0;
        flush_exception = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        test_reset_state();
        test_unsigned();
        test_signed();
        test_zero_divisor();
        test_busy_en();
        test_flush();

        $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
